// File: list.f
source/ecc_pkg.sv
source/ecc_6_hd4_encode.sv
source/ecc_6_hd4_correct.sv
source/ecc_mem_array.sv
source/ecc_syndrome_stage.sv
source/ecc_output_stage.sv
source/ecc_mem_top.sv
bench/tb_clock_gen.sv
bench/tb_ecc_mem.sv

// File: Bender.yml
package:
  name: ecc_mem

sources:
  - files:
      - source/ecc_pkg.sv
      - source/ecc_6_hd4_encode.sv
      - source/ecc_6_hd4_correct.sv
      - source/ecc_mem_array.sv
      - source/ecc_syndrome_stage.sv
      - source/ecc_output_stage.sv
      - source/ecc_mem_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_ecc_mem.sv

// File: bench/tb_ecc_mem.sv
`timescale 1ns/1ns

module tb_ecc_mem
  import ecc_pkg::*;
();

  localparam int DW          = 16;
  localparam int AW          = 4;
  localparam int CW          = DW + ECC_WIDTH;
  localparam int DEPTH       = 2 ** AW;
  localparam int DRAIN_LIMIT = 50;
  localparam int RESET_LIMIT = 20;

  logic                 clk;
  logic                 rst;
  logic                 wr_en;
  logic [AW-1:0]        wr_addr;
  logic [DW-1:0]        wr_data;
  logic [CW-1:0]        wr_flip;
  logic                 rd_en;
  logic [AW-1:0]        rd_addr;
  logic                 corr_disable;
  logic                 rd_valid;
  logic [DW-1:0]        rd_data;
  ecc_status_e          rd_status;
  logic [CNT_WIDTH-1:0] cnt_corrected;
  logic [CNT_WIDTH-1:0] cnt_detected;

  // Reference state holds what was written, with which mask, and what must come back
  logic [DW-1:0]        model_data [0:DEPTH-1];
  logic [CW-1:0]        model_flip [0:DEPTH-1];
  logic [DW-1:0]        exp_data_q [$];
  ecc_status_e          exp_status_q [$];
  logic [CNT_WIDTH-1:0] exp_cnt_corrected = '0;
  logic [CNT_WIDTH-1:0] exp_cnt_detected = '0;
  logic [2:0]           rd_hist = '0;
  int                   errors = 0;
  int                   reads_checked = 0;
  integer               seed = 32'hbcc5_422a;

  tb_clock_gen #(
    .PERIOD       (10),
    .RESET_CYCLES (3)
  ) u_clock (
    .o_clk (clk),
    .o_rst (rst)
  );

  ecc_mem_top #(
    .DATA_WIDTH (DW),
    .ADDR_WIDTH (AW)
  ) DUT (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_wr_en         (wr_en),
    .i_wr_addr       (wr_addr),
    .i_wr_data       (wr_data),
    .i_wr_flip       (wr_flip),
    .i_rd_en         (rd_en),
    .i_rd_addr       (rd_addr),
    .i_corr_disable  (corr_disable),
    .o_rd_valid      (rd_valid),
    .o_rd_data       (rd_data),
    .o_rd_status     (rd_status),
    .o_cnt_corrected (cnt_corrected),
    .o_cnt_detected  (cnt_detected)
  );

  // Expected result follows from the number of flipped bits in the stored word
  function automatic void predict_read(input logic [AW-1:0] addr, input logic dis,
                                       output logic [DW-1:0] data,
                                       output ecc_status_e status);
    logic [DW-1:0] data_flip;
    int            flips;
    data_flip = model_flip[addr][DW-1:0];
    flips     = $countones(model_flip[addr]);
    data      = model_data[addr];
    if (flips == 0) begin
      status = ST_CLEAN;
    end else if (flips == 1) begin
      status = ST_CORRECTED;
      if (dis) begin
        data = data ^ data_flip;
      end
    end else begin
      status = ST_DETECTED;
      data   = data ^ data_flip;
    end
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
    wr_en = 1'b0;
    rd_en = 1'b0;
  endtask

  task automatic write_word(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            input logic [CW-1:0] flip);
    wr_en            = 1'b1;
    wr_addr          = addr;
    wr_data          = data;
    wr_flip          = flip;
    model_data[addr] = data;
    model_flip[addr] = flip;
    next_cycle();
  endtask

  // Sets up a read without ending the cycle, so a write can share it
  task automatic issue_read(input logic [AW-1:0] addr);
    logic [DW-1:0] data;
    ecc_status_e   status;
    predict_read(addr, corr_disable, data, status);
    exp_data_q.push_back(data);
    exp_status_q.push_back(status);
    rd_en   = 1'b1;
    rd_addr = addr;
  endtask

  task automatic read_word(input logic [AW-1:0] addr);
    issue_read(addr);
    next_cycle();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("Timed out waiting for read results, %0d still outstanding",
               exp_data_q.size());
    end
  endtask

  always @(posedge clk) begin : check_outputs
    logic [DW-1:0] want_data;
    ecc_status_e   want_status;
    if (rst) begin
      rd_hist = '0;
    end else begin
      // A read strobe must show up as a result exactly three cycles later
      assert (rd_valid === rd_hist[2]) else begin
        errors++;
        $display("ERROR o_rd_valid: got %h, expected %h", rd_valid, rd_hist[2]);
      end
      if (rd_valid === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("A read result arrived that no read asked for");
        end else begin
          want_data   = exp_data_q.pop_front();
          want_status = exp_status_q.pop_front();
          reads_checked++;
          assert (rd_data === want_data) else begin
            errors++;
            $display("ERROR o_rd_data: got %h, expected %h", rd_data, want_data);
          end
          assert (rd_status === want_status) else begin
            errors++;
            $display("ERROR o_rd_status: got %h, expected %h", rd_status, want_status);
          end
          if (want_status == ST_CORRECTED && exp_cnt_corrected != '1) begin
            exp_cnt_corrected++;
          end
          if (want_status == ST_DETECTED && exp_cnt_detected != '1) begin
            exp_cnt_detected++;
          end
        end
      end
      assert (cnt_corrected === exp_cnt_corrected) else begin
        errors++;
        $display("ERROR o_cnt_corrected: got %h, expected %h",
                 cnt_corrected, exp_cnt_corrected);
      end
      assert (cnt_detected === exp_cnt_detected) else begin
        errors++;
        $display("ERROR o_cnt_detected: got %h, expected %h", cnt_detected, exp_cnt_detected);
      end
      rd_hist = {rd_hist[1:0], rd_en};
    end
  end

  initial begin : stimulus
    int            waited;
    int            pos_a;
    int            pos_b;
    logic [CW-1:0] flip;
    logic [DW-1:0] old_word;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    wr_flip      = '0;
    rd_en        = 1'b0;
    rd_addr      = '0;
    corr_disable = 1'b0;

    waited = 0;
    while (rst !== 1'b0 && waited < RESET_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (rst !== 1'b0) begin
      errors++;
      $display("Timed out waiting for reset to be released");
    end
    #1;
    assert (cnt_corrected === '0 && cnt_detected === '0) else begin
      errors++;
      $display("ERROR o_cnt_corrected/o_cnt_detected after reset: got %h/%h, expected 0/0",
               cnt_corrected, cnt_detected);
    end

    // Clean words, read back on consecutive cycles
    for (int a = 0; a < DEPTH; a++) begin
      write_word(AW'(a), DW'($random(seed)), '0);
    end
    for (int a = 0; a < DEPTH; a++) begin
      read_word(AW'(a));
    end
    wait_drain();

    // One flipped data bit at every position
    for (int b = 0; b < DW; b++) begin
      write_word(AW'(b), DW'($random(seed)), CW'(1) << b);
      read_word(AW'(b));
    end
    wait_drain();

    for (int b = 0; b < ECC_WIDTH; b++) begin
      write_word(AW'(b + 3), DW'($random(seed)), CW'(1) << (DW + b));
      read_word(AW'(b + 3));
    end
    wait_drain();

    // Two distinct random positions anywhere in the codeword
    for (int n = 0; n < 10; n++) begin
      pos_a = {$random(seed)} % CW;
      pos_b = (pos_a + 1 + {$random(seed)} % (CW - 1)) % CW;
      flip  = (CW'(1) << pos_a) | (CW'(1) << pos_b);
      write_word(AW'(n), DW'($random(seed)), flip);
      read_word(AW'(n));
    end
    wait_drain();

    corr_disable = 1'b1;
    for (int b = 0; b < DW; b += 5) begin
      write_word(AW'(b), DW'($random(seed)), CW'(1) << b);
      read_word(AW'(b));
    end
    wait_drain();
    corr_disable = 1'b0;

    // Read and write to one address in the same cycle must return the old word
    old_word = DW'($random(seed));
    write_word(AW'(7), old_word, '0);
    issue_read(AW'(7));
    write_word(AW'(7), ~old_word, '0);
    read_word(AW'(7));
    wait_drain();

    repeat (4) next_cycle();
    $display("Closing summary: %0d reads checked, %0d errors", reads_checked, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD / 2) o_clk = ~o_clk;
    end
  end

  // Reset drops just after an edge, in step with the rest of the stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule

// File: source/ecc_mem_top.sv
`timescale 1ns/1ns

module ecc_mem_top
  import ecc_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_wr_en,
  input  logic [ADDR_WIDTH-1:0]           i_wr_addr,
  input  logic [DATA_WIDTH-1:0]           i_wr_data,
  input  logic [DATA_WIDTH+ECC_WIDTH-1:0] i_wr_flip,
  input  logic                            i_rd_en,
  input  logic [ADDR_WIDTH-1:0]           i_rd_addr,
  input  logic                            i_corr_disable,
  output logic                            o_rd_valid,
  output logic [DATA_WIDTH-1:0]           o_rd_data,
  output ecc_status_e                     o_rd_status,
  output logic [CNT_WIDTH-1:0]            o_cnt_corrected,
  output logic [CNT_WIDTH-1:0]            o_cnt_detected
);

  logic [ECC_WIDTH-1:0]  wr_ecc;
  logic [DATA_WIDTH-1:0] arr_data;
  logic [ECC_WIDTH-1:0]  arr_ecc;
  logic                  arr_valid;
  logic [DATA_WIDTH-1:0] syn_data;
  logic [ECC_WIDTH-1:0]  syn_syndrome;
  logic                  syn_valid;

  ecc_6_hd4_encode #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_wr_encode (
    .i_data (i_wr_data),
    .o_ecc  (wr_ecc)
  );

  ecc_mem_array #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_array (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr_en    (i_wr_en),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data),
    .i_wr_ecc   (wr_ecc),
    .i_wr_flip  (i_wr_flip),
    .i_rd_en    (i_rd_en),
    .i_rd_addr  (i_rd_addr),
    .o_rd_data  (arr_data),
    .o_rd_ecc   (arr_ecc),
    .o_rd_valid (arr_valid)
  );

  ecc_syndrome_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_syndrome (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (arr_valid),
    .i_data     (arr_data),
    .i_ecc      (arr_ecc),
    .o_valid    (syn_valid),
    .o_data     (syn_data),
    .o_syndrome (syn_syndrome)
  );

  ecc_output_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_output (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (syn_valid),
    .i_data          (syn_data),
    .i_syndrome      (syn_syndrome),
    .i_corr_disable  (i_corr_disable),
    .o_valid         (o_rd_valid),
    .o_data          (o_rd_data),
    .o_status        (o_rd_status),
    .o_cnt_corrected (o_cnt_corrected),
    .o_cnt_detected  (o_cnt_detected)
  );

endmodule

// File: source/ecc_output_stage.sv
`timescale 1ns/1ns

module ecc_output_stage
  import ecc_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [DATA_WIDTH-1:0] i_data,
  input  logic [ECC_WIDTH-1:0]  i_syndrome,
  input  logic                  i_corr_disable,
  output logic                  o_valid,
  output logic [DATA_WIDTH-1:0] o_data,
  output ecc_status_e           o_status,
  output logic [CNT_WIDTH-1:0]  o_cnt_corrected,
  output logic [CNT_WIDTH-1:0]  o_cnt_detected
);

  logic [DATA_WIDTH-1:0] data_fixed;
  logic                  corrected;
  logic                  detected;

  ecc_6_hd4_correct #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_correct (
    .i_ecc       (i_syndrome),
    .i_data      (i_data),
    .i_disable   (i_corr_disable),
    .o_data      (data_fixed),
    .o_corrected (corrected),
    .o_detected  (detected)
  );

  always_ff @(posedge i_clk) begin
    o_data <= data_fixed;
    if (detected) begin
      o_status <= ST_DETECTED;
    end else if (corrected) begin
      o_status <= ST_CORRECTED;
    end else begin
      o_status <= ST_CLEAN;
    end
  end

  // Counters move together with the result they describe and stick at all ones
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid         <= 1'b0;
      o_cnt_corrected <= '0;
      o_cnt_detected  <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid && corrected && (o_cnt_corrected != '1)) begin
        o_cnt_corrected <= o_cnt_corrected + 1'b1;
      end
      if (i_valid && detected && (o_cnt_detected != '1)) begin
        o_cnt_detected <= o_cnt_detected + 1'b1;
      end
    end
  end

endmodule

// File: source/ecc_syndrome_stage.sv
`timescale 1ns/1ns

module ecc_syndrome_stage
  import ecc_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [DATA_WIDTH-1:0] i_data,
  input  logic [ECC_WIDTH-1:0]  i_ecc,
  output logic                  o_valid,
  output logic [DATA_WIDTH-1:0] o_data,
  output logic [ECC_WIDTH-1:0]  o_syndrome
);

  logic [ECC_WIDTH-1:0] ecc_calc;

  ecc_6_hd4_encode #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_encode (
    .i_data (i_data),
    .o_ecc  (ecc_calc)
  );

  // The syndrome compares stored against recomputed check bits and is zero for an intact word
  always_ff @(posedge i_clk) begin
    o_data     <= i_data;
    o_syndrome <= ecc_calc ^ i_ecc;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

endmodule

// File: source/ecc_mem_array.sv
`timescale 1ns/1ns

module ecc_mem_array
  import ecc_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_wr_en,
  input  logic [ADDR_WIDTH-1:0]           i_wr_addr,
  input  logic [DATA_WIDTH-1:0]           i_wr_data,
  input  logic [ECC_WIDTH-1:0]            i_wr_ecc,
  input  logic [DATA_WIDTH+ECC_WIDTH-1:0] i_wr_flip,
  input  logic                            i_rd_en,
  input  logic [ADDR_WIDTH-1:0]           i_rd_addr,
  output logic [DATA_WIDTH-1:0]           o_rd_data,
  output logic [ECC_WIDTH-1:0]            o_rd_ecc,
  output logic                            o_rd_valid
);

  localparam int CW_WIDTH = DATA_WIDTH + ECC_WIDTH;
  localparam int DEPTH    = 2 ** ADDR_WIDTH;

  logic [CW_WIDTH-1:0] mem [0:DEPTH-1];
  logic [CW_WIDTH-1:0] rd_word;
  logic                rd_valid;

  // Check bits sit above the data and the flip mask corrupts the stored word
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= {i_wr_ecc, i_wr_data} ^ i_wr_flip;
    end
    // Nonblocking update gives the old word on a same-address collision
    if (i_rd_en) begin
      rd_word <= mem[i_rd_addr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= i_rd_en;
    end
  end

  assign o_rd_data  = rd_word[DATA_WIDTH-1:0];
  assign o_rd_ecc   = rd_word[CW_WIDTH-1:DATA_WIDTH];
  assign o_rd_valid = rd_valid;

endmodule

// File: source/ecc_6_hd4_correct.sv
`timescale 1ns/1ns

module ecc_6_hd4_correct
  import ecc_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic [ECC_WIDTH-1:0]  i_ecc,
  input  logic [DATA_WIDTH-1:0] i_data,
  // Only the data fix is suppressed while the event flags stay active
  input  logic                  i_disable,
  output logic [DATA_WIDTH-1:0] o_data,
  output logic                  o_corrected,
  output logic                  o_detected
);

  logic [DATA_WIDTH-1:0] data;
  logic                  corrected;
  logic                  detected;

  always_comb begin
    // Any nonzero syndrome starts out as an uncorrectable event
    corrected = 1'b0;
    detected  = (i_ecc != '0);
    data      = i_data;

    // A unit vector points at one of the stored check bits
    for (int n = 0; n < ECC_WIDTH; n++) begin
      if (i_ecc == (ECC_WIDTH'(1) << n)) begin
        corrected = 1'b1;
        detected  = 1'b0;
      end
    end

    // A match with a data column locates the flipped data bit
    for (int n = 0; n < DATA_WIDTH; n++) begin
      if (i_ecc == ecc_column(n)) begin
        corrected = 1'b1;
        detected  = 1'b0;
        data[n]   = ~i_data[n];
      end
    end
  end

  assign o_data      = i_disable ? i_data : data;
  assign o_corrected = corrected;
  assign o_detected  = detected;

endmodule

// File: source/ecc_6_hd4_encode.sv
`timescale 1ns/1ns

module ecc_6_hd4_encode
  import ecc_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic [DATA_WIDTH-1:0] i_data,
  output logic [ECC_WIDTH-1:0]  o_ecc
);

  logic [ECC_WIDTH-1:0] ecc;

  // Each set data bit contributes its column to the check word
  always_comb begin
    ecc = '0;
    for (int n = 0; n < DATA_WIDTH; n++) begin
      if (i_data[n]) begin
        ecc = ecc ^ ecc_column(n);
      end
    end
  end

  assign o_ecc = ecc;

endmodule

// File: source/ecc_pkg.sv
package ecc_pkg;

  // Check bits per codeword
  localparam int ECC_WIDTH = 6;

  // Longest data word that keeps distance 4 with the 0x47 column table
  localparam int MAX_DATA_WIDTH = 25;

  localparam int CNT_WIDTH = 16;

  typedef enum logic [1:0] {
    ST_CLEAN     = 2'd0,
    ST_CORRECTED = 2'd1,
    ST_DETECTED  = 2'd2
  } ecc_status_e;

  // Syndrome column of data bit idx as generated from polynomial 0x47
  function automatic logic [ECC_WIDTH-1:0] ecc_column(input int idx);
    logic [ECC_WIDTH-1:0] col;
    col = '0;
    if (idx < MAX_DATA_WIDTH) begin
      case (idx)
        0:  col = 6'h07;
        1:  col = 6'h0e;
        2:  col = 6'h1c;
        3:  col = 6'h38;
        4:  col = 6'h37;
        5:  col = 6'h29;
        6:  col = 6'h15;
        7:  col = 6'h2a;
        8:  col = 6'h13;
        9:  col = 6'h26;
        10: col = 6'h0b;
        11: col = 6'h16;
        12: col = 6'h2c;
        13: col = 6'h1f;
        14: col = 6'h3e;
        15: col = 6'h3b;
        16: col = 6'h31;
        17: col = 6'h25;
        18: col = 6'h0d;
        19: col = 6'h1a;
        20: col = 6'h34;
        21: col = 6'h2f;
        22: col = 6'h19;
        23: col = 6'h32;
        default: col = 6'h23;
      endcase
    end
    return col;
  endfunction

endpackage
